/* rtl/fpu_config.svh */
// --------------------------------------------------
// Sizing constants for the FP16 coprocessor
// Included by the package, the RTL and the testbench
// --------------------------------------------------
`ifndef FPU_CONFIG_SVH
`define FPU_CONFIG_SVH

// Command FIFO entries, also the host's initial command credits
`define FPU_CMD_DEPTH 4
// Response FIFO entries, also the FSM's initial response credits
`define FPU_RSP_DEPTH 4
// One quotient bit per execute cycle
`define FPU_DIV_CYCLES 12
`define FPU_TAG_W 4

`endif

/* rtl/fpu_pkg.sv */
// --------------------------------------------------
// Shared types for the FP16 coprocessor
// Imported by the RTL modules and the testbench
// --------------------------------------------------
`include "fpu_config.svh"

package fpu_pkg;

    typedef enum logic [1:0] {
        FADD = 2'd0,
        FSUB = 2'd1,
        FMUL = 2'd2,
        FDIV = 2'd3
    } fpu_op_t;

    // Half precision, bias 15
    typedef struct packed {
        logic       sign;
        logic [4:0] exp;
        logic [9:0] frac;
    } fpu_half_t;

    typedef struct packed {
        fpu_op_t                 op;
        fpu_half_t               a;
        fpu_half_t               b;
        logic [`FPU_TAG_W-1:0]   tag;
    } fpu_cmd_t;

    typedef struct packed {
        logic invalid;
        logic div_zero;
        logic overflow;
    } fpu_flags_t;

    typedef struct packed {
        logic [`FPU_TAG_W-1:0]   tag;
        fpu_half_t               result;
        fpu_flags_t              flags;
    } fpu_rsp_t;

    // At most one enable high per cycle
    typedef struct packed {
        logic decode;
        logic unpack;
        logic execute;
        logic normalize;
        logic round;
        logic pack;
    } fpu_stage_en_t;

endpackage

/* rtl/fpu_credit_fifo.sv */
`timescale 1ns/1ps
// --------------------------------------------------
// Circular FIFO with credit flow control on both sides
// Forwards one entry per downstream credit as a pulse
// --------------------------------------------------
module fpu_credit_fifo #(
    parameter type ENTRY_T      = logic [7:0],
    parameter int  DEPTH        = 4,
    parameter int  INIT_CREDITS = 0
) (
    input  logic   clk,
    input  logic   rst_n,
    input  logic   in_valid,
    input  ENTRY_T in_data,
    input  logic   credit_in,
    output logic   out_valid,
    output ENTRY_T out_data,
    output logic   credit_out
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    ENTRY_T           mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic [CNT_W-1:0] credits;
    logic             fwd;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] p);
        if (p == PTR_W'(DEPTH - 1)) begin
            return '0;
        end
        return p + 1'b1;
    endfunction

    // Forward only with data and a downstream credit
    assign fwd = (count != '0) && (credits != '0);

    always_ff @(posedge clk) begin
        if (in_valid) begin
            mem[wr_ptr] <= in_data;
        end
        if (fwd) begin
            out_data <= mem[rd_ptr];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            count      <= '0;
            credits    <= CNT_W'(INIT_CREDITS);
            out_valid  <= 1'b0;
            credit_out <= 1'b0;
        end else begin
            out_valid  <= fwd;
            credit_out <= fwd;
            if (in_valid) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (fwd) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            count   <= count + CNT_W'(in_valid) - CNT_W'(fwd);
            credits <= credits + CNT_W'(credit_in) - CNT_W'(fwd);
        end
    end

    // Upstream must respect the credits it was given
    a_no_push_full: assert property (@(posedge clk) disable iff (!rst_n)
        in_valid |-> (count < CNT_W'(DEPTH)));

    a_credit_bound: assert property (@(posedge clk) disable iff (!rst_n)
        credits <= CNT_W'(DEPTH));

endmodule

/* rtl/fpu_ctrl_fsm.sv */
`timescale 1ns/1ps
// --------------------------------------------------
// Sequencing FSM, one command at a time
// Issues stage enables and handles both credit loops
// --------------------------------------------------
`include "fpu_config.svh"

module fpu_ctrl_fsm
    import fpu_pkg::*;
(
    input  logic          clk,
    input  logic          rst_n,
    input  logic          cmd_valid,
    input  fpu_op_t       cmd_op,
    input  logic          rsp_credit,
    input  logic          exc_any,
    output fpu_stage_en_t stage_en,
    output logic          div_step,
    output logic          cmd_credit,
    output logic          rsp_push,
    output logic          busy
);

    localparam int DIV_CNT_W = $clog2(`FPU_DIV_CYCLES);
    localparam int RSP_CNT_W = $clog2(`FPU_RSP_DEPTH + 1);

    typedef enum logic [3:0] {
        S_IDLE,
        S_DECODE,
        S_UNPACK,
        S_EXECUTE,
        S_NORMALIZE,
        S_ROUND,
        S_PACK,
        S_COMPLETE,
        S_EXCEPTION
    } state_t;

    state_t               state;
    state_t               state_nxt;
    fpu_op_t              op_q;
    logic [DIV_CNT_W-1:0] div_cnt;
    logic [RSP_CNT_W-1:0] rsp_cnt;
    logic                 cmd_granted;
    logic                 grant;
    logic                 exec_done;

    assign exec_done = (op_q != FDIV) || (div_cnt == DIV_CNT_W'(`FPU_DIV_CYCLES - 1));

    // Hold back the next command until a response slot is reserved
    assign grant = (state == S_IDLE) && !cmd_granted && !rsp_push && (rsp_cnt != '0);

    always_comb begin
        state_nxt = state;
        case (state)
            S_IDLE:      if (cmd_valid) state_nxt = S_DECODE;
            S_DECODE:    state_nxt = S_UNPACK;
            S_UNPACK:    state_nxt = exc_any ? S_EXCEPTION : S_EXECUTE;
            S_EXECUTE:   if (exec_done) state_nxt = S_NORMALIZE;
            S_NORMALIZE: state_nxt = S_ROUND;
            S_ROUND:     state_nxt = exc_any ? S_EXCEPTION : S_PACK;
            S_PACK:      state_nxt = S_COMPLETE;
            default:     state_nxt = S_IDLE;
        endcase
    end

    always_comb begin
        stage_en           = '0;
        stage_en.decode    = (state == S_DECODE);
        stage_en.unpack    = (state == S_UNPACK);
        stage_en.execute   = (state == S_EXECUTE);
        stage_en.normalize = (state == S_NORMALIZE);
        stage_en.round     = (state == S_ROUND);
        stage_en.pack      = (state == S_PACK);
    end

    assign div_step = (state == S_EXECUTE) && (op_q == FDIV);
    assign busy     = (state != S_IDLE);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state       <= S_IDLE;
            op_q        <= FADD;
            div_cnt     <= '0;
            rsp_cnt     <= RSP_CNT_W'(`FPU_RSP_DEPTH);
            cmd_granted <= 1'b0;
            cmd_credit  <= 1'b0;
            rsp_push    <= 1'b0;
        end else begin
            state <= state_nxt;
            if ((state == S_IDLE) && cmd_valid) begin
                op_q <= cmd_op;
            end
            if ((state == S_EXECUTE) && !exec_done) begin
                div_cnt <= div_cnt + 1'b1;
            end else begin
                div_cnt <= '0;
            end
            rsp_push   <= (state == S_COMPLETE) || (state == S_EXCEPTION);
            rsp_cnt    <= rsp_cnt + RSP_CNT_W'(rsp_credit) - RSP_CNT_W'(rsp_push);
            cmd_credit <= grant;
            if (grant) begin
                cmd_granted <= 1'b1;
            end else if (cmd_valid) begin
                cmd_granted <= 1'b0;
            end
        end
    end

    // No new command while a stage is active
    a_stage_onehot: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0({stage_en, cmd_valid}));

    // Credit was checked when the command was admitted
    a_push_credit: assert property (@(posedge clk) disable iff (!rst_n)
        rsp_push |-> (rsp_cnt != '0));

endmodule

/* rtl/fpu_datapath.sv */
`timescale 1ns/1ps
// --------------------------------------------------
// FP16 stage registers and arithmetic, truncating
// Each stage register loads on its FSM enable
// --------------------------------------------------
module fpu_datapath
    import fpu_pkg::*;
(
    input  logic          clk,
    input  logic          rst_n,
    input  fpu_cmd_t      cmd,
    input  fpu_stage_en_t stage_en,
    input  logic          div_step,
    output fpu_flags_t    exc,
    output logic          exc_any,
    output fpu_rsp_t      rsp
);

    fpu_cmd_t          cmd_q;
    logic              sign_a;
    logic              sign_b;
    logic [4:0]        exp_a;
    logic [4:0]        exp_b;
    logic [10:0]       man_a;
    logic [10:0]       man_b;
    logic              res_sign;
    logic signed [7:0] res_exp;
    logic [23:0]       res_man;
    logic [11:0]       div_rem;
    logic [11:0]       div_q;
    logic              n_sign;
    logic signed [7:0] n_exp;
    logic [9:0]        n_frac;
    logic              n_zero;
    fpu_half_t         rnd_q;
    fpu_half_t         result_q;
    fpu_flags_t        flags_q;

    logic              a_big;
    logic [10:0]       big_m;
    logic [10:0]       small_al;
    logic [4:0]        big_e;
    logic              big_s;
    logic [11:0]       sum;
    logic [21:0]       prod;
    logic [11:0]       div_diff;
    logic              div_ge;
    logic [23:0]       pre_man;
    logic [23:0]       norm_man;
    logic [4:0]        lead;

    // Alignment by magnitude, shifted-out bits are dropped
    always_comb begin
        a_big    = {exp_a, man_a} >= {exp_b, man_b};
        big_m    = a_big ? man_a : man_b;
        big_e    = a_big ? exp_a : exp_b;
        big_s    = a_big ? sign_a : sign_b;
        small_al = (a_big ? man_b : man_a) >> (big_e - (a_big ? exp_b : exp_a));
        if (sign_a == sign_b) begin
            sum = {1'b0, big_m} + {1'b0, small_al};
        end else begin
            sum = {1'b0, big_m} - {1'b0, small_al};
        end
    end

    assign prod     = man_a * man_b;
    assign div_diff = div_rem - {1'b0, man_b};
    assign div_ge   = div_rem >= {1'b0, man_b};

    // Unit weight sits at bit 22 for every operation
    assign pre_man = (cmd_q.op == FDIV) ? {1'b0, div_q, 11'd0} : res_man;

    always_comb begin
        lead = 5'd0;
        for (int i = 0; i < 24; i++) begin
            if (pre_man[i]) lead = 5'(i);
        end
        if (lead == 5'd23) begin
            norm_man = pre_man >> 1;
        end else begin
            norm_man = pre_man << (5'd22 - lead);
        end
    end

    always_comb begin
        exc = '0;
        if (stage_en.unpack) begin
            exc.invalid  = (cmd_q.a.exp == 5'h1f) || (cmd_q.b.exp == 5'h1f);
            exc.div_zero = (cmd_q.op == FDIV) && (cmd_q.b.exp == 5'd0);
        end
        if (stage_en.round) begin
            exc.overflow = !n_zero && (n_exp >= 8'sd31);
        end
    end

    assign exc_any = |exc;

    always_ff @(posedge clk) begin
        if (stage_en.decode) begin
            cmd_q <= cmd;
        end
        // Subnormals flush to signed zero
        if (stage_en.unpack) begin
            sign_a  <= cmd_q.a.sign;
            sign_b  <= cmd_q.b.sign ^ (cmd_q.op == FSUB);
            exp_a   <= cmd_q.a.exp;
            exp_b   <= cmd_q.b.exp;
            man_a   <= (cmd_q.a.exp == 5'd0) ? 11'd0 : {1'b1, cmd_q.a.frac};
            man_b   <= (cmd_q.b.exp == 5'd0) ? 11'd0 : {1'b1, cmd_q.b.frac};
            div_rem <= (cmd_q.a.exp == 5'd0) ? 12'd0 : {2'b01, cmd_q.a.frac};
            div_q   <= '0;
        end
        if (stage_en.execute) begin
            case (cmd_q.op)
                FADD, FSUB: begin
                    res_sign <= (sum == 12'd0) ? 1'b0 : big_s;
                    res_exp  <= $signed({3'b000, big_e});
                    res_man  <= {sum, 12'd0};
                end
                FMUL: begin
                    res_sign <= sign_a ^ sign_b;
                    res_exp  <= $signed({3'b000, exp_a}) + $signed({3'b000, exp_b}) - 8'sd15;
                    res_man  <= {prod, 2'b00};
                end
                default: begin
                    res_sign <= sign_a ^ sign_b;
                    res_exp  <= $signed({3'b000, exp_a}) - $signed({3'b000, exp_b}) + 8'sd15;
                    // Restoring step, integer bit first
                    if (div_step) begin
                        div_q   <= {div_q[10:0], div_ge};
                        div_rem <= (div_ge ? div_diff : div_rem) << 1;
                    end
                end
            endcase
        end
        if (stage_en.normalize) begin
            n_sign <= res_sign;
            n_exp  <= res_exp + $signed({3'b000, lead}) - 8'sd22;
            n_frac <= norm_man[21:12];
            n_zero <= (pre_man == 24'd0);
        end
        // Truncation, underflow goes to signed zero
        if (stage_en.round) begin
            rnd_q.sign <= n_sign;
            if (n_zero || (n_exp <= 8'sd0)) begin
                rnd_q.exp  <= 5'd0;
                rnd_q.frac <= 10'd0;
            end else begin
                rnd_q.exp  <= n_exp[4:0];
                rnd_q.frac <= n_frac;
            end
        end
        if (stage_en.pack) begin
            result_q <= rnd_q;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            flags_q <= '0;
        end else if (stage_en.decode) begin
            flags_q <= '0;
        end else begin
            flags_q <= flags_q | exc;
        end
    end

    assign rsp.tag    = cmd_q.tag;
    assign rsp.flags  = flags_q;
    assign rsp.result = (flags_q != '0) ? '0 : result_q;

endmodule

/* rtl/fpu_coproc_top.sv */
`timescale 1ns/1ps
// --------------------------------------------------
// FP16 coprocessor top, credit-based command/response
// --------------------------------------------------
`include "fpu_config.svh"

module fpu_coproc_top
    import fpu_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  logic     cmd_valid,
    input  fpu_cmd_t cmd,
    output logic     cmd_credit,
    output logic     rsp_valid,
    output fpu_rsp_t rsp,
    input  logic     rsp_credit,
    output logic     busy
);

    logic          fifo_cmd_valid;
    fpu_cmd_t      fifo_cmd;
    logic          fsm_cmd_credit;
    fpu_stage_en_t stage_en;
    logic          div_step;
    logic          dp_exc_any;
    fpu_rsp_t      dp_rsp;
    logic          rsp_push;
    logic          fsm_rsp_credit;

    // The FSM hands out its single credit itself
    fpu_credit_fifo #(
        .ENTRY_T      (fpu_cmd_t),
        .DEPTH        (`FPU_CMD_DEPTH),
        .INIT_CREDITS (0)
    ) i_cmd_fifo (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_valid   (cmd_valid),
        .in_data    (cmd),
        .credit_in  (fsm_cmd_credit),
        .out_valid  (fifo_cmd_valid),
        .out_data   (fifo_cmd),
        .credit_out (cmd_credit)
    );

    fpu_ctrl_fsm i_ctrl_fsm (
        .clk        (clk),
        .rst_n      (rst_n),
        .cmd_valid  (fifo_cmd_valid),
        .cmd_op     (fifo_cmd.op),
        .rsp_credit (fsm_rsp_credit),
        .exc_any    (dp_exc_any),
        .stage_en   (stage_en),
        .div_step   (div_step),
        .cmd_credit (fsm_cmd_credit),
        .rsp_push   (rsp_push),
        .busy       (busy)
    );

    fpu_datapath i_datapath (
        .clk      (clk),
        .rst_n    (rst_n),
        .cmd      (fifo_cmd),
        .stage_en (stage_en),
        .div_step (div_step),
        .exc      (),
        .exc_any  (dp_exc_any),
        .rsp      (dp_rsp)
    );

    // Host grants response credits one at a time
    fpu_credit_fifo #(
        .ENTRY_T      (fpu_rsp_t),
        .DEPTH        (`FPU_RSP_DEPTH),
        .INIT_CREDITS (0)
    ) i_rsp_fifo (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_valid   (rsp_push),
        .in_data    (dp_rsp),
        .credit_in  (rsp_credit),
        .out_valid  (rsp_valid),
        .out_data   (rsp),
        .credit_out (fsm_rsp_credit)
    );

endmodule

/* sim/fpu_tb_model.svh */
// --------------------------------------------------
// Reference model of the FP16 truncation rules
// Included inside the testbench module
// --------------------------------------------------
`ifndef FPU_TB_MODEL_SVH
`define FPU_TB_MODEL_SVH

// Position of the leading one
function automatic int msb_index(input logic [31:0] v);
    int idx;
    idx = 0;
    for (int i = 0; i < 32; i++) begin
        if (v[i]) idx = i;
    end
    return idx;
endfunction

function automatic fpu_rsp_t expected_rsp(input fpu_cmd_t c);
    fpu_rsp_t    r;
    logic [31:0] ma;
    logic [31:0] mb;
    logic [31:0] mag;
    logic        sb;
    logic        s;
    int          e;
    int          p;
    int          scale;
    r                = '0;
    r.tag            = c.tag;
    r.flags.invalid  = (c.a.exp == 5'd31) || (c.b.exp == 5'd31);
    r.flags.div_zero = (c.op == FDIV) && (c.b.exp == 5'd0);
    if (r.flags.invalid || r.flags.div_zero) return r;
    // Subnormals count as zero
    ma = (c.a.exp == 5'd0) ? 32'd0 : {21'd0, 1'b1, c.a.frac};
    mb = (c.b.exp == 5'd0) ? 32'd0 : {21'd0, 1'b1, c.b.frac};
    sb = c.b.sign ^ (c.op == FSUB);
    case (c.op)
        FMUL: begin
            s     = c.a.sign ^ c.b.sign;
            mag   = ma * mb;
            e     = int'(c.a.exp) + int'(c.b.exp) - 15;
            scale = 20;
        end
        FDIV: begin
            s     = c.a.sign ^ c.b.sign;
            mag   = (ma << 11) / mb;
            e     = int'(c.a.exp) - int'(c.b.exp) + 15;
            scale = 11;
        end
        default: begin
            // Larger magnitude sets exponent and sign
            if ({c.a.exp, ma[10:0]} >= {c.b.exp, mb[10:0]}) begin
                e  = c.a.exp;
                s  = c.a.sign;
                mb = mb >> (int'(c.a.exp) - int'(c.b.exp));
                mag = (c.a.sign == sb) ? ma + mb : ma - mb;
            end else begin
                e  = c.b.exp;
                s  = sb;
                ma = ma >> (int'(c.b.exp) - int'(c.a.exp));
                mag = (c.a.sign == sb) ? mb + ma : mb - ma;
            end
            if (mag == 32'd0) s = 1'b0;
            scale = 10;
        end
    endcase
    r.result.sign = s;
    if (mag == 32'd0) return r;
    p = msb_index(mag);
    e = e + p - scale;
    if (e >= 31) begin
        r.result         = '0;
        r.flags.overflow = 1'b1;
        return r;
    end
    if (e <= 0) return r;
    r.result.exp  = 5'(e);
    r.result.frac = (p >= 10) ? 10'(mag >> (p - 10)) : 10'(mag << (10 - p));
    return r;
endfunction

`endif

/* sim/tb_fpu_coproc.sv */
`timescale 1ns/1ps
// --------------------------------------------------
// Random credit-aware testbench for the FP16 coprocessor
// Scoreboards every response against the reference model
// --------------------------------------------------
`include "fpu_config.svh"

module tb_fpu_coproc
    import fpu_pkg::*;
();

    localparam int TIMEOUT = 2000;

    logic        clk;
    logic        rst_n;
    logic        cmd_valid;
    fpu_cmd_t    cmd;
    logic        cmd_credit;
    logic        rsp_valid;
    fpu_rsp_t    rsp;
    logic        rsp_credit;
    logic        busy;

    fpu_rsp_t    exp_q[$];
    int          cmd_credits;
    int          rsp_granted;
    bit          grant_en;
    logic [`FPU_TAG_W-1:0] tag_cnt;

    `include "fpu_tb_model.svh"

    fpu_coproc_top i_fpu_coproc_top (
        .clk        (clk),
        .rst_n      (rst_n),
        .cmd_valid  (cmd_valid),
        .cmd        (cmd),
        .cmd_credit (cmd_credit),
        .rsp_valid  (rsp_valid),
        .rsp        (rsp),
        .rsp_credit (rsp_credit),
        .busy       (busy)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("Testbench failed");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic check_flags(input fpu_flags_t got, input fpu_flags_t want);
        if (got !== want) begin
            abort_run($sformatf("Fail %0t: flags %b, expected %b", $time, got, want));
        end
    endtask

    task automatic check_rsp(input fpu_rsp_t got, input fpu_rsp_t want);
        if (got.tag !== want.tag) begin
            abort_run($sformatf("Fail %0t: tag %0d, expected %0d", $time, got.tag, want.tag));
        end
        check_flags(got.flags, want.flags);
        if (got.result !== want.result) begin
            abort_run($sformatf("Fail %0t: tag %0d result %h, expected %h",
                                $time, got.tag, got.result, want.result));
        end
    endtask

    // Sample on the falling edge, then drive the next cycle
    task automatic tick();
        @(negedge clk);
        if (cmd_credit) begin
            cmd_credits++;
        end
        if (rsp_valid) begin
            if (rsp_granted == 0) begin
                abort_run("A response appeared without a response credit");
            end
            if (exp_q.size() == 0) begin
                abort_run("A response arrived with no command outstanding");
            end
            check_rsp(rsp, exp_q.pop_front());
            rsp_granted--;
        end
        cmd_valid  = 1'b0;
        rsp_credit = 1'b0;
        if (grant_en && (rsp_granted < int'(exp_q.size())) && (rsp_granted < `FPU_RSP_DEPTH)
            && ($urandom_range(1, 0) == 1)) begin
            rsp_credit = 1'b1;
            rsp_granted++;
        end
    endtask

    task automatic push_cmd(input fpu_cmd_t c);
        c.tag     = tag_cnt;
        tag_cnt   = tag_cnt + 1'b1;
        cmd_valid = 1'b1;
        cmd       = c;
        cmd_credits--;
        exp_q.push_back(expected_rsp(c));
    endtask

    task automatic send_cmd(input fpu_cmd_t c);
        int waited;
        waited = 0;
        tick();
        while (cmd_credits == 0) begin
            if (waited >= TIMEOUT) begin
                abort_run("Timed out waiting for a command credit");
            end
            waited++;
            tick();
        end
        push_cmd(c);
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        while (exp_q.size() != 0) begin
            if (waited >= TIMEOUT) begin
                abort_run("Timed out waiting for outstanding responses");
            end
            waited++;
            tick();
        end
        if (cmd_credits != `FPU_CMD_DEPTH) begin
            abort_run("Command credits did not return to the full count");
        end
    endtask

    function automatic fpu_half_t rand_half(input int lo, input int hi);
        fpu_half_t h;
        h.sign = 1'($urandom_range(1, 0));
        h.exp  = 5'($urandom_range(hi, lo));
        h.frac = 10'($urandom);
        return h;
    endfunction

    function automatic fpu_cmd_t rand_cmd(input fpu_op_t op, input int a_lo, input int a_hi,
                                          input int b_lo, input int b_hi);
        fpu_cmd_t c;
        c.op  = op;
        c.a   = rand_half(a_lo, a_hi);
        c.b   = rand_half(b_lo, b_hi);
        c.tag = '0;
        return c;
    endfunction

    function automatic fpu_op_t rand_op();
        return fpu_op_t'(2'($urandom_range(3, 0)));
    endfunction

    initial begin
        fpu_cmd_t c;
        int       sent;
        void'($urandom(32'h76ae4f82));
        rst_n       = 1'b0;
        cmd_valid   = 1'b0;
        cmd         = '0;
        rsp_credit  = 1'b0;
        cmd_credits = `FPU_CMD_DEPTH;
        rsp_granted = 0;
        grant_en    = 1'b1;
        tag_cnt     = '0;
        repeat (10) @(negedge clk);
        rst_n = 1'b1;

        // Idle after reset
        repeat (8) begin
            tick();
            if (cmd_credit || rsp_valid || busy) begin
                abort_run("DUT outputs active after reset with no commands sent");
            end
        end
        drain();

        // Normal operands, all operations
        repeat (200) begin
            send_cmd(rand_cmd(rand_op(), 1, 30, 1, 30));
        end
        drain();

        // Invalid, divide by zero and subnormal inputs
        for (int i = 0; i < 60; i++) begin
            c = rand_cmd(rand_op(), 0, 31, 0, 31);
            if (i % 3 == 0) begin
                c.a.exp = 5'd31;
            end else if (i % 3 == 1) begin
                c.op    = FDIV;
                c.b.exp = 5'd0;
            end
            send_cmd(c);
        end
        drain();

        // Overflow and underflow
        for (int i = 0; i < 60; i++) begin
            case (i % 4)
                0:       send_cmd(rand_cmd(FMUL, 24, 30, 24, 30));
                1:       send_cmd(rand_cmd(FMUL, 1, 6, 1, 6));
                2:       send_cmd(rand_cmd(FDIV, 28, 30, 1, 3));
                default: send_cmd(rand_cmd(FDIV, 1, 3, 28, 30));
            endcase
        end
        drain();

        // Back-pressure with response credits withheld
        grant_en = 1'b0;
        sent     = 0;
        repeat (400) begin
            tick();
            if ((cmd_credits > 0) && (sent < 12)) begin
                push_cmd(rand_cmd(rand_op(), 1, 30, 1, 30));
                sent++;
            end
        end
        if (sent != `FPU_CMD_DEPTH + `FPU_RSP_DEPTH) begin
            abort_run($sformatf("Command credits kept flowing under back-pressure, %0d sent",
                                sent));
        end
        grant_en = 1'b1;
        drain();

        $display("Testbench passed");
        $finish;
    end

endmodule

/* fpu_coproc.f */
+incdir+rtl
+incdir+sim
rtl/fpu_pkg.sv
rtl/fpu_credit_fifo.sv
rtl/fpu_ctrl_fsm.sv
rtl/fpu_datapath.sv
rtl/fpu_coproc_top.sv
sim/tb_fpu_coproc.sv

/* Makefile */
# Verilator build and run for the FP16 coprocessor testbench

VERILATOR ?= verilator
TOP       ?= tb_fpu_coproc
FILELIST  ?= fpu_coproc.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Testbench passed
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SIM_BIN = $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(SIM_BIN) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "Simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
